// ==== tlul_monitor.f ====
common/tlul_mon_pkg.sv
rtl/tlul_pend_table.sv
rtl/tlul_req_check.sv
rtl/tlul_rsp_check.sv
rtl/tlul_viol_count.sv
rtl/tlul_monitor.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_tlul_monitor.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tl-ul monitor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_tlul_monitor \
  -f tlul_monitor.f \
  -o sim_tlul_monitor

./obj_dir/sim_tlul_monitor > sim.log 2>&1
cat sim.log

# the log decides the outcome
if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// ==== dv/tb_tlul_monitor.sv ====
////////////////////
// tl-ul monitor testbench
// directed and random beats on both channels,
// checker compares every cycle, watchdog bounds the run
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_tlul_monitor;

  import tlul_mon_pkg::*;

  localparam int SourceW    = 4;
  localparam int AddrW      = 32;
  // small counter so saturation is reached
  localparam int CntW       = 4;
  localparam int ClkPeriod  = 8;
  localparam int RstCycles  = 3;
  localparam int DirCycles  = 60;
  localparam int RandCycles = 400;
  localparam int MaxCycles  = RstCycles + DirCycles + RandCycles + 50;

  logic clk;
  logic rst_n;

  logic                a_valid_i;
  logic                a_ready_i;
  logic [TlOpW-1:0]    a_opcode_i;
  logic [TlParamW-1:0] a_param_i;
  logic [TlSzw-1:0]    a_size_i;
  logic [SourceW-1:0]  a_source_i;
  logic [AddrW-1:0]    a_address_i;
  logic [TlDbw-1:0]    a_mask_i;
  logic                d_valid_i;
  logic                d_ready_i;
  logic [TlOpW-1:0]    d_opcode_i;
  logic [TlParamW-1:0] d_param_i;
  logic [TlSzw-1:0]    d_size_i;
  logic [SourceW-1:0]  d_source_i;
  logic [ReqViolW-1:0] req_viol_o;
  logic [RspViolW-1:0] rsp_viol_o;
  logic [CntW-1:0]     viol_cnt_o;

  logic        final_chk;
  int          req_errs;
  int          rsp_errs;
  int          cnt_errs;
  logic [31:0] lfsr;
  logic [31:0] rnd;
  logic [2:0]  op_pick;
  // beat presented last cycle and not accepted
  logic        a_hold;
  logic        d_hold;

  tb_clkgen #(
    .PeriodNs  (ClkPeriod),
    .RstCycles (RstCycles)
  ) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tlul_monitor #(
    .SourceW (SourceW),
    .AddrW   (AddrW),
    .CntW    (CntW)
  ) uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .a_valid_i   (a_valid_i),
    .a_ready_i   (a_ready_i),
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .d_valid_i   (d_valid_i),
    .d_ready_i   (d_ready_i),
    .d_opcode_i  (d_opcode_i),
    .d_param_i   (d_param_i),
    .d_size_i    (d_size_i),
    .d_source_i  (d_source_i),
    .req_viol_o  (req_viol_o),
    .rsp_viol_o  (rsp_viol_o),
    .viol_cnt_o  (viol_cnt_o)
  );

  tb_checker #(
    .SourceW (SourceW),
    .AddrW   (AddrW),
    .CntW    (CntW)
  ) u_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .a_valid_i   (a_valid_i),
    .a_ready_i   (a_ready_i),
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .d_valid_i   (d_valid_i),
    .d_ready_i   (d_ready_i),
    .d_opcode_i  (d_opcode_i),
    .d_param_i   (d_param_i),
    .d_size_i    (d_size_i),
    .d_source_i  (d_source_i),
    .req_viol_i  (req_viol_o),
    .rsp_viol_i  (rsp_viol_o),
    .viol_cnt_i  (viol_cnt_o),
    .final_i     (final_chk),
    .req_errs_o  (req_errs),
    .rsp_errs_o  (rsp_errs),
    .cnt_errs_o  (cnt_errs)
  );

  ////////////////////
  // random source
  ////////////////////

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // bus drivers
  ////////////////////

  // one a-channel beat, d channel idle
  task automatic send_req(input logic rdy, input logic [TlOpW-1:0] op,
                          input logic [TlParamW-1:0] prm, input logic [TlSzw-1:0] sz,
                          input logic [SourceW-1:0] src, input logic [AddrW-1:0] addr,
                          input logic [TlDbw-1:0] msk);
    @(posedge clk);
    a_valid_i   <= 1'b1;
    a_ready_i   <= rdy;
    a_opcode_i  <= op;
    a_param_i   <= prm;
    a_size_i    <= sz;
    a_source_i  <= src;
    a_address_i <= addr;
    a_mask_i    <= msk;
    d_valid_i   <= 1'b0;
    d_ready_i   <= 1'b0;
  endtask

  // one d-channel beat, a channel idle
  task automatic send_rsp(input logic rdy, input logic [TlOpW-1:0] op,
                          input logic [TlParamW-1:0] prm, input logic [TlSzw-1:0] sz,
                          input logic [SourceW-1:0] src);
    @(posedge clk);
    d_valid_i  <= 1'b1;
    d_ready_i  <= rdy;
    d_opcode_i <= op;
    d_param_i  <= prm;
    d_size_i   <= sz;
    d_source_i <= src;
    a_valid_i  <= 1'b0;
    a_ready_i  <= 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    a_valid_i <= 1'b0;
    a_ready_i <= 1'b0;
    d_valid_i <= 1'b0;
    d_ready_i <= 1'b0;
  endtask

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    #(MaxCycles * ClkPeriod);
    $display("timeout: the stimulus did not finish within %0d cycles", MaxCycles);
    $display("Regression failed");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    a_valid_i   <= 1'b0;
    a_ready_i   <= 1'b0;
    a_opcode_i  <= '0;
    a_param_i   <= '0;
    a_size_i    <= '0;
    a_source_i  <= '0;
    a_address_i <= '0;
    a_mask_i    <= '0;
    d_valid_i   <= 1'b0;
    d_ready_i   <= 1'b0;
    d_opcode_i  <= '0;
    d_param_i   <= '0;
    d_size_i    <= '0;
    d_source_i  <= '0;
    final_chk   <= 1'b0;
    lfsr = 32'h9ac1;
    @(posedge rst_n);

    // legal traffic on distinct sources, all answered
    send_req(1'b1, Get, 3'h0, 2'd2, 4'd1, 32'h100, 4'hf);
    send_req(1'b1, PutFullData, 3'h0, 2'd1, 4'd2, 32'h202, 4'hc);
    send_req(1'b1, PutPartialData, 3'h0, 2'd2, 4'd3, 32'h300, 4'h5);
    send_rsp(1'b1, AccessAckData, 3'h0, 2'd2, 4'd1);
    send_rsp(1'b1, AccessAck, 3'h0, 2'd1, 4'd2);
    send_rsp(1'b1, AccessAck, 3'h0, 2'd2, 4'd3);
    idle_cycle();

    // one request rule each, held off so the table stays idle
    send_req(1'b0, 3'h2, 3'h0, 2'd2, 4'd4, 32'h0, 4'hf);
    send_req(1'b0, Get, 3'h1, 2'd2, 4'd4, 32'h0, 4'hf);
    send_req(1'b0, Get, 3'h0, 2'd1, 4'd4, 32'h0, 4'hf);
    send_req(1'b0, PutFullData, 3'h0, 2'd2, 4'd4, 32'h0, 4'h3);
    send_req(1'b0, Get, 3'h0, 2'd2, 4'd4, 32'h102, 4'hf);
    send_req(1'b0, Get, 3'h0, 2'd2, 4'd4, 32'h0, 4'h5);
    idle_cycle();

    // duplicate on a busy source, clean again after the response
    send_req(1'b1, Get, 3'h0, 2'd2, 4'd5, 32'h500, 4'hf);
    send_req(1'b0, Get, 3'h0, 2'd2, 4'd5, 32'h500, 4'hf);
    send_rsp(1'b1, AccessAckData, 3'h0, 2'd2, 4'd5);
    send_req(1'b1, Get, 3'h0, 2'd2, 4'd5, 32'h500, 4'hf);
    send_rsp(1'b1, AccessAckData, 3'h0, 2'd2, 4'd5);
    idle_cycle();

    // response rules against a pending full put
    send_req(1'b1, PutFullData, 3'h0, 2'd2, 4'd6, 32'h600, 4'hf);
    send_rsp(1'b0, AccessAckData, 3'h0, 2'd2, 4'd6);
    send_rsp(1'b0, AccessAck, 3'h1, 2'd2, 4'd6);
    send_rsp(1'b0, AccessAck, 3'h0, 2'd1, 4'd6);
    send_rsp(1'b1, AccessAck, 3'h0, 2'd2, 4'd6);
    // nothing outstanding on source 7
    send_rsp(1'b1, AccessAck, 3'h0, 2'd0, 4'd7);
    idle_cycle();

    // random beats and back-pressure on a few sources
    for (int n = 0; n < RandCycles; n++) begin
      @(posedge clk);
      // a beat that was not accepted stays on the bus unchanged
      a_hold = a_valid_i && !a_ready_i;
      d_hold = d_valid_i && !d_ready_i;
      if (!a_hold) begin
        take_bits(2, rnd);
        case (rnd[1:0])
          2'd0: op_pick = PutFullData;
          2'd1: op_pick = PutPartialData;
          2'd2: op_pick = Get;
          default: begin
            take_bits(3, rnd);
            op_pick = rnd[2:0];
          end
        endcase
        a_opcode_i <= op_pick;
        take_bits(1, rnd);
        a_valid_i <= rnd[0];
        // nonzero param now and then
        take_bits(3, rnd);
        a_param_i <= (rnd[2:0] == 3'h7) ? 3'h1 : 3'h0;
        take_bits(2, rnd);
        a_size_i <= rnd[1:0];
        take_bits(3, rnd);
        a_source_i <= SourceW'(rnd[2:0]);
        take_bits(4, rnd);
        a_address_i <= AddrW'(rnd[3:0]);
        take_bits(4, rnd);
        a_mask_i <= rnd[3:0];
      end
      take_bits(1, rnd);
      a_ready_i <= rnd[0];
      if (!d_hold) begin
        take_bits(1, rnd);
        d_valid_i <= rnd[0];
        take_bits(1, rnd);
        d_opcode_i <= {2'b00, rnd[0]};
        take_bits(3, rnd);
        d_param_i <= (rnd[2:0] == 3'h7) ? 3'h1 : 3'h0;
        take_bits(2, rnd);
        d_size_i <= rnd[1:0];
        take_bits(3, rnd);
        d_source_i <= SourceW'(rnd[2:0]);
      end
      take_bits(1, rnd);
      d_ready_i <= rnd[0];
    end

    // flush the flag and counter stages
    repeat (4) idle_cycle();
    @(posedge clk);
    final_chk <= 1'b1;
    repeat (2) idle_cycle();

    $display("errors: req_viol=%0d rsp_viol=%0d viol_cnt=%0d", req_errs, rsp_errs, cnt_errs);
    if ((req_errs + rsp_errs + cnt_errs) == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
////////////////////
// tl-ul monitor checker
// models the pending table, the flag pipeline and the
// saturating counter, compares all dut outputs each cycle
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int SourceW = 4,
  parameter int AddrW   = 32,
  parameter int CntW    = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              a_valid_i,
  input  wire logic                              a_ready_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]    a_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0] a_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]    a_size_i,
  input  wire logic [SourceW-1:0]                a_source_i,
  input  wire logic [AddrW-1:0]                  a_address_i,
  input  wire logic [tlul_mon_pkg::TlDbw-1:0]    a_mask_i,
  input  wire logic                              d_valid_i,
  input  wire logic                              d_ready_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]    d_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0] d_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]    d_size_i,
  input  wire logic [SourceW-1:0]                d_source_i,
  input  wire logic [tlul_mon_pkg::ReqViolW-1:0] req_viol_i,
  input  wire logic [tlul_mon_pkg::RspViolW-1:0] rsp_viol_i,
  input  wire logic [CntW-1:0]                   viol_cnt_i,
  // one-shot check that the counter reached all ones
  input  wire logic                              final_i,
  output int                                     req_errs_o,
  output int                                     rsp_errs_o,
  output int                                     cnt_errs_o
);

  import tlul_mon_pkg::*;

  localparam int Entries = 2 ** SourceW;

  // table model
  logic             pend_m   [Entries];
  logic             is_get_m [Entries];
  logic [TlSzw-1:0] size_m   [Entries];

  // flags expected on the outputs after the next edge
  logic [ReqViolW-1:0]          exp_req;
  logic [RspViolW-1:0]          exp_rsp;
  logic [CntW-1:0]              exp_cnt;
  logic [ReqViolW+RspViolW-1:0] flags;
  logic                         final_seen;

  ////////////////////
  // reference model
  ////////////////////

  // returns {response flags, request flags}
  function automatic logic [ReqViolW+RspViolW-1:0] expected_flags(
    input logic                a_valid,
    input logic [TlOpW-1:0]    a_op,
    input logic [TlParamW-1:0] a_param,
    input logic [TlSzw-1:0]    a_size,
    input logic [AddrW-1:0]    a_addr,
    input logic [TlDbw-1:0]    a_mask,
    input logic                a_pend,
    input logic                d_valid,
    input logic [TlOpW-1:0]    d_op,
    input logic [TlParamW-1:0] d_param,
    input logic [TlSzw-1:0]    d_size,
    input logic                d_pend,
    input logic                d_is_get,
    input logic [TlSzw-1:0]    d_pend_size
  );
    logic [ReqViolW-1:0] req;
    logic [RspViolW-1:0] rsp;
    int                  ones;
    int                  first;
    int                  last;
    int                  nbytes;
    logic                contig;
    req    = '0;
    rsp    = '0;
    ones   = 0;
    first  = -1;
    last   = -1;
    nbytes = 1 << a_size;
    // find the span of enabled lanes
    for (int i = 0; i < TlDbw; i++) begin
      if (a_mask[i]) begin
        ones++;
        if (first < 0) begin
          first = i;
        end
        last = i;
      end
    end
    // contiguous when the span holds only ones
    contig = (ones == 0) || ((last - first + 1) == ones);
    if (a_valid) begin
      req[ReqOpcode]      = !(a_op inside {PutFullData, PutPartialData, Get});
      req[ReqParam]       = (a_param != '0);
      req[ReqSizeGteMask] = (a_op != PutFullData) && (nbytes < ones);
      req[ReqSizeEqMask]  = (a_op == PutFullData) && (nbytes != ones);
      req[ReqPendDup]     = a_pend;
      req[ReqAddrAlign]   = ((a_addr % AddrW'(nbytes)) != '0);
      req[ReqContigMask]  = (a_op != PutPartialData) && !contig;
    end
    if (d_valid) begin
      rsp[RspOpcode] = d_is_get ? (d_op != AccessAckData) : (d_op != AccessAck);
      rsp[RspParam]  = (d_param != '0);
      rsp[RspSize]   = (d_size != d_pend_size);
      rsp[RspNoReq]  = !d_pend;
    end
    return {rsp, req};
  endfunction

  ////////////////////
  // compare and step
  ////////////////////

  // falling edge, inputs and outputs are both settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < Entries; i++) begin
        pend_m[i]   = 1'b0;
        is_get_m[i] = 1'b0;
        size_m[i]   = '0;
      end
      exp_req    = '0;
      exp_rsp    = '0;
      exp_cnt    = '0;
      final_seen = 1'b0;
      req_errs_o = 0;
      rsp_errs_o = 0;
      cnt_errs_o = 0;
    end else begin
      if (req_viol_i !== exp_req) begin
        $display("ERROR: req_viol_o is 0x%0h, expected 0x%0h at %0t", req_viol_i, exp_req,
                 $time);
        req_errs_o++;
      end
      if (rsp_viol_i !== exp_rsp) begin
        $display("ERROR: rsp_viol_o is 0x%0h, expected 0x%0h at %0t", rsp_viol_i, exp_rsp,
                 $time);
        rsp_errs_o++;
      end
      if (viol_cnt_i !== exp_cnt) begin
        $display("ERROR: viol_cnt_o is 0x%0h, expected 0x%0h at %0t", viol_cnt_i, exp_cnt,
                 $time);
        cnt_errs_o++;
      end
      if (final_i && !final_seen) begin
        final_seen = 1'b1;
        if (viol_cnt_i !== {CntW{1'b1}}) begin
          $display("ERROR: viol_cnt_o is 0x%0h, expected saturation at 0x%0h", viol_cnt_i,
                   {CntW{1'b1}});
          cnt_errs_o++;
        end
      end
      // counter sees the flags now on the outputs
      if (((|exp_req) || (|exp_rsp)) && (exp_cnt != {CntW{1'b1}})) begin
        exp_cnt = exp_cnt + CntW'(1);
      end
      // flags of this cycle show up after the next edge
      flags = expected_flags(a_valid_i, a_opcode_i, a_param_i, a_size_i, a_address_i,
                             a_mask_i, pend_m[a_source_i], d_valid_i, d_opcode_i,
                             d_param_i, d_size_i, pend_m[d_source_i],
                             is_get_m[d_source_i], size_m[d_source_i]);
      exp_req = flags[ReqViolW-1:0];
      exp_rsp = flags[ReqViolW+RspViolW-1:ReqViolW];
      // table only moves on accepted beats, clear after set
      if (a_valid_i && a_ready_i) begin
        pend_m[a_source_i]   = 1'b1;
        is_get_m[a_source_i] = (a_opcode_i == Get);
        size_m[a_source_i]   = a_size_i;
      end
      if (d_valid_i && d_ready_i) begin
        pend_m[d_source_i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
////////////////////
// testbench clock and reset
// free running clock, reset low for a fixed number of cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PeriodNs  = 8,
  parameter int RstCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the flops
  initial begin
    rst_no <= 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== rtl/tlul_monitor.sv ====
////////////////////
// tl-ul protocol monitor
// passive observer of one host-to-device port, reports
// malformed a-channel requests, mismatching d-channel
// responses and a count of violating cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tlul_monitor #(
  parameter int SourceW = 4,
  parameter int AddrW   = 32,
  parameter int CntW    = 16
) (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  // a channel
  input  wire logic                               a_valid_i,
  input  wire logic                               a_ready_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]     a_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0]  a_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]     a_size_i,
  input  wire logic [SourceW-1:0]                 a_source_i,
  input  wire logic [AddrW-1:0]                   a_address_i,
  input  wire logic [tlul_mon_pkg::TlDbw-1:0]     a_mask_i,
  // d channel
  input  wire logic                               d_valid_i,
  input  wire logic                               d_ready_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]     d_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0]  d_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]     d_size_i,
  input  wire logic [SourceW-1:0]                 d_source_i,
  // violation reports
  output logic      [tlul_mon_pkg::ReqViolW-1:0]  req_viol_o,
  output logic      [tlul_mon_pkg::RspViolW-1:0]  rsp_viol_o,
  output logic      [CntW-1:0]                    viol_cnt_o
);

  import tlul_mon_pkg::*;

  // table lookups for the current a and d sources
  logic             a_pend;
  logic             d_pend;
  logic             d_pend_is_get;
  logic [TlSzw-1:0] d_pend_size;

  ////////////////////
  // pending requests
  ////////////////////

  tlul_pend_table #(
    .SourceW (SourceW)
  ) u_pend_table (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .a_valid_i       (a_valid_i),
    .a_ready_i       (a_ready_i),
    .a_opcode_i      (a_opcode_i),
    .a_size_i        (a_size_i),
    .a_source_i      (a_source_i),
    .d_valid_i       (d_valid_i),
    .d_ready_i       (d_ready_i),
    .d_source_i      (d_source_i),
    .a_pend_o        (a_pend),
    .d_pend_o        (d_pend),
    .d_pend_is_get_o (d_pend_is_get),
    .d_pend_size_o   (d_pend_size)
  );

  ////////////////////
  // channel checkers
  ////////////////////

  tlul_req_check #(
    .SourceW (SourceW),
    .AddrW   (AddrW)
  ) u_req_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_pend_i    (a_pend),
    .req_viol_o  (req_viol_o)
  );

  tlul_rsp_check #(
    .SourceW (SourceW)
  ) u_rsp_check (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .d_valid_i       (d_valid_i),
    .d_opcode_i      (d_opcode_i),
    .d_param_i       (d_param_i),
    .d_size_i        (d_size_i),
    .d_pend_i        (d_pend),
    .d_pend_is_get_i (d_pend_is_get),
    .d_pend_size_i   (d_pend_size),
    .rsp_viol_o      (rsp_viol_o)
  );

  // counts cycles with any registered flag set
  tlul_viol_count #(
    .CntW (CntW)
  ) u_viol_count (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_viol_i (req_viol_o),
    .rsp_viol_i (rsp_viol_o),
    .viol_cnt_o (viol_cnt_o)
  );

endmodule

`default_nettype wire

// ==== rtl/tlul_viol_count.sv ====
////////////////////
// violation cycle counter
// saturating count of cycles with any flag set
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tlul_viol_count #(
  parameter int CntW = 16
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [tlul_mon_pkg::ReqViolW-1:0] req_viol_i,
  input  wire logic [tlul_mon_pkg::RspViolW-1:0] rsp_viol_i,
  output logic      [CntW-1:0]                   viol_cnt_o
);

  // one count per cycle, however many bits are set
  logic hit;
  logic cnt_max;

  assign hit     = (|req_viol_i) | (|rsp_viol_i);
  assign cnt_max = &viol_cnt_o;

  // holds at all ones once reached
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_cnt_o <= '0;
    end else if (hit && !cnt_max) begin
      viol_cnt_o <= viol_cnt_o + CntW'(1);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tlul_rsp_check.sv ====
////////////////////
// tl-ul d-channel checker
// compares each valid response with the pending
// entry of its source, flags one cycle later
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tlul_rsp_check #(
  parameter int SourceW = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              d_valid_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]    d_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0] d_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]    d_size_i,
  input  wire logic                              d_pend_i,
  input  wire logic                              d_pend_is_get_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]    d_pend_size_i,
  output logic      [tlul_mon_pkg::RspViolW-1:0] rsp_viol_o
);

  import tlul_mon_pkg::*;

  tl_d_op_e            exp_op;
  logic [RspViolW-1:0] rsp_viol_d;

  // get returns data, puts only acknowledge
  assign exp_op = d_pend_is_get_i ? AccessAckData : AccessAck;

  always_comb begin
    rsp_viol_d = '0;
    if (d_valid_i) begin
      rsp_viol_d[RspOpcode] = (d_opcode_i != exp_op);
      rsp_viol_d[RspParam]  = |d_param_i;
      rsp_viol_d[RspSize]   = (d_size_i != d_pend_size_i);
      // response to a source with nothing outstanding
      rsp_viol_d[RspNoReq]  = !d_pend_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_viol_o <= '0;
    end else begin
      rsp_viol_o <= rsp_viol_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tlul_req_check.sv ====
////////////////////
// tl-ul a-channel checker
// flags malformed requests in every valid cycle,
// one cycle after the beat
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tlul_req_check #(
  parameter int SourceW = 4,
  parameter int AddrW   = 32
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              a_valid_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0]    a_opcode_i,
  input  wire logic [tlul_mon_pkg::TlParamW-1:0] a_param_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0]    a_size_i,
  input  wire logic [AddrW-1:0]                  a_address_i,
  input  wire logic [tlul_mon_pkg::TlDbw-1:0]    a_mask_i,
  input  wire logic                              a_pend_i,
  output logic      [tlul_mon_pkg::ReqViolW-1:0] req_viol_o
);

  import tlul_mon_pkg::*;

  // wide enough for 2**size at the largest size code
  localparam int SizeBytesW = 2 ** TlSzw;

  logic [SizeBytesW-1:0] size_bytes;
  logic [SizeBytesW-1:0] size_lsbs;
  logic [AddrW-1:0]      addr_lsbs;
  logic [SizeBytesW-1:0] mask_ones;
  logic [TlDbw-1:0]      mask_edges;
  logic [SizeBytesW-1:0] edge_cnt;
  logic                  legal_op;
  logic [ReqViolW-1:0]   req_viol_d;

  ////////////////////
  // datapath helpers
  ////////////////////

  // byte count of the transfer and the address bits it covers
  assign size_bytes = SizeBytesW'(1) << a_size_i;
  assign size_lsbs  = size_bytes - SizeBytesW'(1);
  assign addr_lsbs  = AddrW'(size_lsbs);

  assign mask_ones = SizeBytesW'($countones(a_mask_i));

  // 0/1 transitions with a zero shifted in at the bottom,
  // a contiguous run of ones has at most two
  assign mask_edges = a_mask_i ^ {a_mask_i[TlDbw-2:0], 1'b0};
  assign edge_cnt   = SizeBytesW'($countones(mask_edges));

  assign legal_op = (a_opcode_i == PutFullData) ||
                    (a_opcode_i == PutPartialData) ||
                    (a_opcode_i == Get);

  ////////////////////
  // rule evaluation
  ////////////////////

  always_comb begin
    req_viol_d = '0;
    // every presented beat is checked, accepted or not
    if (a_valid_i) begin
      req_viol_d[ReqOpcode]      = !legal_op;
      req_viol_d[ReqParam]       = |a_param_i;
      // partial put and get may cover fewer lanes than their size
      req_viol_d[ReqSizeGteMask] = (a_opcode_i != PutFullData) && (size_bytes < mask_ones);
      // full put must enable exactly 2**size lanes
      req_viol_d[ReqSizeEqMask]  = (a_opcode_i == PutFullData) && (size_bytes != mask_ones);
      req_viol_d[ReqPendDup]     = a_pend_i;
      req_viol_d[ReqAddrAlign]   = |(a_address_i & addr_lsbs);
      req_viol_d[ReqContigMask]  = (a_opcode_i != PutPartialData) &&
                                   (edge_cnt > SizeBytesW'(2));
    end
  end

  // flags for the previous cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_viol_o <= '0;
    end else begin
      req_viol_o <= req_viol_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tlul_pend_table.sv ====
////////////////////
// tl-ul pending request table
// one entry per source id, set by accepted requests,
// cleared by accepted responses
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tlul_pend_table #(
  parameter int SourceW = 4
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           a_valid_i,
  input  wire logic                           a_ready_i,
  input  wire logic [tlul_mon_pkg::TlOpW-1:0] a_opcode_i,
  input  wire logic [tlul_mon_pkg::TlSzw-1:0] a_size_i,
  input  wire logic [SourceW-1:0]             a_source_i,
  input  wire logic                           d_valid_i,
  input  wire logic                           d_ready_i,
  input  wire logic [SourceW-1:0]             d_source_i,
  output logic                                a_pend_o,
  output logic                                d_pend_o,
  output logic                                d_pend_is_get_o,
  output logic      [tlul_mon_pkg::TlSzw-1:0] d_pend_size_o
);

  import tlul_mon_pkg::*;

  localparam int Entries = 2 ** SourceW;

  // per-entry fields
  // pend   - at most one request outstanding per source
  // is_get - get needs AccessAckData, puts need AccessAck
  // size   - d_size must echo a_size
  logic [Entries-1:0]            pend_q;
  logic [Entries-1:0]            is_get_q;
  logic [Entries-1:0][TlSzw-1:0] size_q;

  // beats that actually complete their handshake
  logic a_acc;
  logic d_acc;

  assign a_acc = a_valid_i & a_ready_i;
  assign d_acc = d_valid_i & d_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      is_get_q <= '0;
      size_q   <= '0;
    end else begin
      if (a_acc) begin
        pend_q[a_source_i]   <= 1'b1;
        is_get_q[a_source_i] <= (a_opcode_i == Get);
        size_q[a_source_i]   <= a_size_i;
      end
      // placed after the set so that a same-source
      // request and response leave the entry idle
      if (d_acc) begin
        pend_q[d_source_i] <= 1'b0;
      end
    end
  end

  // lookups see the state from before this edge
  assign a_pend_o        = pend_q[a_source_i];
  assign d_pend_o        = pend_q[d_source_i];
  assign d_pend_is_get_o = is_get_q[d_source_i];
  assign d_pend_size_o   = size_q[d_source_i];

endmodule

`default_nettype wire

// ==== common/tlul_mon_pkg.sv ====
////////////////////
// tl-ul monitor shared definitions
// bus field widths, channel opcodes and the
// bit positions of the request and response flags
////////////////////

`default_nettype none

package tlul_mon_pkg;

  ////////////////////
  // bus field widths
  ////////////////////

  // bytes per bus word, one mask bit per byte
  parameter int TlDbw = 4;
  // a_size / d_size width, log2 of the byte count
  parameter int TlSzw = 2;
  parameter int TlOpW = 3;
  // a_param and d_param are reserved in tl-ul
  parameter int TlParamW = 3;

  ////////////////////
  // opcodes
  ////////////////////

  // a channel, only these three exist in tl-ul
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // d channel, data comes back only for a get
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  ////////////////////
  // flag bit positions
  ////////////////////

  // request flags
  parameter int ReqViolW       = 7;
  parameter int ReqOpcode      = 0;
  parameter int ReqParam       = 1;
  parameter int ReqSizeGteMask = 2;
  parameter int ReqSizeEqMask  = 3;
  parameter int ReqPendDup     = 4;
  parameter int ReqAddrAlign   = 5;
  parameter int ReqContigMask  = 6;

  // response flags
  parameter int RspViolW = 4;
  parameter int RspOpcode = 0;
  parameter int RspParam  = 1;
  parameter int RspSize   = 2;
  parameter int RspNoReq  = 3;

endpackage

`default_nettype wire
